//--- sim.f
logic/rvPkg.sv
logic/alu.sv
logic/regFile.sv
logic/dataCache.sv
logic/controlFsm.sv
logic/datapath.sv
logic/riscvTop.sv
sim/riscvTop_assertions.sv
sim/tbRiscv.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbRiscv
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- sim/tbRiscv.sv
`timescale 1ns/1ps

module tbRiscv;
	import rvPkg::*;

	localparam int progLen = 60;
	localparam int memWords = 1024;
	localparam int haltTimeout = 3000;
	localparam logic [31:0] ebreakWord = 32'h00100073;

	logic CLK;
	logic rstN;
	logic iMemCsN;
	logic [addrWidth-1:0] iMemAddr;
	logic [31:0] iMemDi;
	logic dMemCsN;
	logic dMemWen;
	logic [addrWidth-3:0] dMemAddr;
	logic [31:0] dMemDout;
	logic [31:0] dMemDi;
	logic rfWe;
	logic [4:0] rfWa;
	logic [31:0] rfWd;
	logic halt;
	logic [31:0] numInst;

	logic [31:0] imem [memWords];
	logic [31:0] dmem [memWords];
	logic [31:0] modelMem [memWords];
	logic [31:0] modelReg [32];
	logic [addrWidth-3:0] rdAddr;
	int kind [progLen];
	int jump [progLen];
	logic [4:0] rdF [progLen];
	logic [4:0] rs1F [progLen];
	logic [4:0] rs2F [progLen];
	logic [31:0] immF [progLen];
	logic [4:0] expWa [$];
	logic [31:0] expWd [$];
	integer seed;
	int errCount;
	int timeoutCount;
	int checkCount;
	int modelCount;
	int nWrites;
	int cycles;

	riscvTop #(
		.cacheLines(4)
	) dut0 (
		.CLK(CLK), .rstN(rstN), .iMemCsN(iMemCsN), .iMemAddr(iMemAddr), .iMemDi(iMemDi),
		.dMemCsN(dMemCsN), .dMemWen(dMemWen), .dMemAddr(dMemAddr), .dMemDout(dMemDout),
		.dMemDi(dMemDi), .rfWe(rfWe), .rfWa(rfWa), .rfWd(rfWd), .halt(halt),
		.numInst(numInst)
	);

	always #5 CLK = ~CLK;

	// instruction fetch of the current pc driven mid-cycle
	always @(negedge CLK)
		iMemDi <= imem[iMemAddr[addrWidth-1:2]];

	// data memory writes at the edge and returns read data a cycle later
	always @(posedge CLK) begin
		if (!dMemCsN) begin
			if (dMemWen)
				dmem[dMemAddr] <= dMemDout;
			else
				rdAddr <= dMemAddr;
		end
	end

	always @(negedge CLK)
		dMemDi <= dmem[rdAddr];

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic logic [31:0] fillWord(input int a);
		logic [9:0] w;
		w = a[9:0];
		return {6'h2d, w, 6'h12, ~w};
	endfunction

	// random program with forward jumps only and loads and stores off x0
	task automatic genProgram();
		int k;
		int off;
		logic [31:0] r;
		logic [31:0] imm;
		logic [31:0] w;
		logic [31:0] lastAddr;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		lastAddr = 32'd0;
		for (int i = 0; i < progLen; i++) begin
			r = $random(seed);
			k = int'(r % 32'd11);
			r = $random(seed);
			rd = {2'b00, r[2:0]};
			rs1 = {2'b00, r[5:3]};
			// equal operands now and then so BEQ gets taken
			rs2 = r[6] ? rs1 : {2'b00, r[9:7]};
			off = 1 + int'(r % 32'd6);
			if (off > progLen - i)
				off = progLen - i;
			r = $random(seed);
			imm = 32'd0;
			if (k == 6)
				imm = {{20{r[11]}}, r[11:0]};
			if (k == 7 || k == 8) begin
				rs1 = 5'd0;
				// half the accesses reuse the last data address to hit the cache
				imm = r[6] ? lastAddr : {24'd0, r[5:0], 2'b00};
				lastAddr = imm;
			end
			if (k == 9 || k == 10)
				imm = off * 4;
			case (k)
				0: w = {7'd0, rs2, rs1, 3'b000, rd, opReg};
				1: w = {7'b0100000, rs2, rs1, 3'b000, rd, opReg};
				2: w = {7'd0, rs2, rs1, 3'b111, rd, opReg};
				3: w = {7'd0, rs2, rs1, 3'b110, rd, opReg};
				4: w = {7'd0, rs2, rs1, 3'b100, rd, opReg};
				5: w = {7'd0, rs2, rs1, 3'b010, rd, opReg};
				6: w = {imm[11:0], rs1, 3'b000, rd, opImm};
				7: w = {imm[11:0], rs1, 3'b010, rd, opLoad};
				8: w = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
				9: w = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
				default: w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
			endcase
			imem[i] = w;
			kind[i] = k;
			jump[i] = off;
			rdF[i] = rd;
			rs1F[i] = rs1;
			rs2F[i] = rs2;
			immF[i] = imm;
		end
		imem[progLen] = ebreakWord;
	endtask

	// ISA-level execution of the same program
	task automatic runModel();
		int pc;
		int k;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		logic wr;
		for (int j = 0; j < 32; j++)
			modelReg[j] = 32'd0;
		pc = 0;
		modelCount = 0;
		while (pc < progLen) begin
			k = kind[pc];
			a = modelReg[rs1F[pc]];
			b = modelReg[rs2F[pc]];
			addr = a + immF[pc];
			wr = 1'b1;
			res = 32'd0;
			case (k)
				0: res = a + b;
				1: res = a - b;
				2: res = a & b;
				3: res = a | b;
				4: res = a ^ b;
				5: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				6: res = addr;
				7: res = modelMem[addr[11:2]];
				8: begin
					modelMem[addr[11:2]] = b;
					wr = 1'b0;
				end
				9: wr = 1'b0;
				default: res = pc * 4 + 4;
			endcase
			if (wr && rdF[pc] != 5'd0) begin
				modelReg[rdF[pc]] = res;
				expWa.push_back(rdF[pc]);
				expWd.push_back(res);
			end
			modelCount++;
			if ((k == 9 && a == b) || k == 10)
				pc = pc + jump[pc];
			else
				pc++;
		end
	endtask

	initial begin
		seed = 32'haaaf_d166;
		CLK = 1'b0;
		rstN = 1'b0;
		iMemDi <= 32'd0;
		dMemDi <= 32'd0;
		rdAddr <= '0;
		errCount = 0;
		timeoutCount = 0;
		checkCount = 0;
		nWrites = 0;
		cycles = 0;
		for (int a = 0; a < memWords; a++) begin
			imem[a] = ebreakWord;
			dmem[a] <= fillWord(a);
			modelMem[a] = fillWord(a);
		end
		genProgram();
		runModel();

		for (int c = 0; c < 16; c++) begin
			@(negedge CLK);
			checkValue("halt in reset", {31'd0, halt}, 32'd0);
			checkValue("rfWe in reset", {31'd0, rfWe}, 32'd0);
			checkValue("numInst in reset", numInst, 32'd0);
			checkValue("iMemCsN in reset", {31'd0, iMemCsN}, 32'd1);
			checkValue("dMemCsN in reset", {31'd0, dMemCsN}, 32'd1);
		end
		rstN = 1'b1;
		@(negedge CLK);
		// first cycle out of reset
		checkValue("first iMemAddr", {20'd0, iMemAddr}, 32'd0);
		checkValue("halt after reset", {31'd0, halt}, 32'd0);
		checkValue("rfWe after reset", {31'd0, rfWe}, 32'd0);
		checkValue("numInst after reset", numInst, 32'd0);
		checkValue("dMemCsN after reset", {31'd0, dMemCsN}, 32'd1);

		while (!halt && cycles < haltTimeout) begin
			@(negedge CLK);
			cycles++;
			if (rfWe && rfWa != 5'd0) begin
				if (nWrites < expWa.size()) begin
					checkValue("register write address", {27'd0, rfWa}, {27'd0, expWa[nWrites]});
					checkValue("register write data", rfWd, expWd[nWrites]);
				end
				nWrites++;
			end
		end
		if (!halt) begin
			timeoutCount++;
			$display("Timeout: halt did not rise after the EBREAK was fetched");
		end

		checkValue("register write count", nWrites, expWa.size());
		checkValue("retired instruction count", numInst, modelCount);
		for (int a = 0; a < memWords; a++)
			checkValue($sformatf("data memory word %0d", a), dmem[a], modelMem[a]);

		$display("checks %0d, mismatches %0d, timeouts %0d", checkCount, errCount,
			timeoutCount);
		if (errCount == 0 && timeoutCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- sim/riscvTop_assertions.sv
`timescale 1ns/1ps

module riscvTopAssertions (
	input logic CLK,
	input logic rstN,
	input logic halt,
	input logic iMemCsN,
	input logic dMemCsN,
	input logic rfWe
);

	// once halted the core stays halted
	haltSticky: assert property (@(posedge CLK) disable iff (!rstN) halt |=> halt)
		else $error("halt fell after it had risen");

	// fetch and data access never share a cycle
	oneMemory: assert property (@(posedge CLK) disable iff (!rstN) !(!iMemCsN && !dMemCsN))
		else $error("instruction and data chip selects low in the same cycle");

	noWriteHalted: assert property (@(posedge CLK) disable iff (!rstN) !(rfWe && halt))
		else $error("register write while halted");

endmodule

bind riscvTop riscvTopAssertions checks0 (
	.CLK(CLK), .rstN(rstN), .halt(halt), .iMemCsN(iMemCsN), .dMemCsN(dMemCsN), .rfWe(rfWe)
);

//--- logic/riscvTop.sv
`timescale 1ns/1ps

module riscvTop #(
	parameter int cacheLines = 16
) (
	input  logic CLK,
	input  logic rstN,
	output logic iMemCsN,
	output logic [rvPkg::addrWidth-1:0] iMemAddr,
	input  logic [31:0] iMemDi,
	output logic dMemCsN,
	output logic dMemWen,
	output logic [rvPkg::addrWidth-3:0] dMemAddr,
	output logic [31:0] dMemDout,
	input  logic [31:0] dMemDi,
	output logic rfWe,
	output logic [4:0] rfWa,
	output logic [31:0] rfWd,
	output logic halt,
	output logic [31:0] numInst
);
	import rvPkg::*;

	rvInstr instr;
	logic aluZero;
	logic stall;
	logic irWrite;
	logic pcWrite;
	logic pcSel;
	logic abWrite;
	logic aluOutWrite;
	logic mdrWrite;
	logic [1:0] aluSrcA;
	logic [1:0] aluSrcB;
	logic [1:0] immSel;
	logic [3:0] aluOp;
	logic [1:0] wbSel;
	logic memRead;
	logic memWrite;
	logic [addrWidth-1:0] cacheAddr;
	logic [31:0] cacheWdata;
	logic [31:0] cacheRdata;

	controlFsm control0 (
		.CLK(CLK), .rstN(rstN), .instr(instr), .aluZero(aluZero), .stall(stall),
		.iMemCsN(iMemCsN), .irWrite(irWrite), .pcWrite(pcWrite), .pcSel(pcSel),
		.abWrite(abWrite), .aluOutWrite(aluOutWrite), .mdrWrite(mdrWrite),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .immSel(immSel), .aluOp(aluOp),
		.wbSel(wbSel), .rfWe(rfWe), .memRead(memRead), .memWrite(memWrite),
		.halt(halt), .numInst(numInst)
	);

	datapath datapath0 (
		.CLK(CLK), .rstN(rstN), .iMemDi(iMemDi), .iMemAddr(iMemAddr), .instr(instr),
		.irWrite(irWrite), .pcWrite(pcWrite), .pcSel(pcSel), .abWrite(abWrite),
		.aluOutWrite(aluOutWrite), .mdrWrite(mdrWrite), .aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB), .immSel(immSel), .aluOp(aluOp), .wbSel(wbSel), .rfWe(rfWe),
		.aluZero(aluZero), .cacheAddr(cacheAddr), .cacheWdata(cacheWdata),
		.cacheRdata(cacheRdata), .rfWa(rfWa), .rfWd(rfWd)
	);

	dataCache #(
		.cacheLines(cacheLines)
	) cache0 (
		.CLK(CLK), .rstN(rstN), .memRead(memRead), .memWrite(memWrite),
		.addr(cacheAddr), .wdata(cacheWdata), .rdata(cacheRdata), .stall(stall),
		.dMemCsN(dMemCsN), .dMemWen(dMemWen), .dMemAddr(dMemAddr),
		.dMemDout(dMemDout), .dMemDi(dMemDi)
	);

endmodule

//--- logic/datapath.sv
`timescale 1ns/1ps

module datapath (
	input  logic CLK,
	input  logic rstN,
	input  logic [31:0] iMemDi,
	output logic [rvPkg::addrWidth-1:0] iMemAddr,
	output rvPkg::rvInstr instr,
	input  logic irWrite,
	input  logic pcWrite,
	input  logic pcSel,
	input  logic abWrite,
	input  logic aluOutWrite,
	input  logic mdrWrite,
	input  logic [1:0] aluSrcA,
	input  logic [1:0] aluSrcB,
	input  logic [1:0] immSel,
	input  logic [3:0] aluOp,
	input  logic [1:0] wbSel,
	input  logic rfWe,
	output logic aluZero,
	output logic [rvPkg::addrWidth-1:0] cacheAddr,
	output logic [31:0] cacheWdata,
	input  logic [31:0] cacheRdata,
	output logic [4:0] rfWa,
	output logic [31:0] rfWd
);
	import rvPkg::*;

	logic [addrWidth-1:0] pc;
	logic [addrWidth-1:0] oldPc;
	logic [31:0] aReg;
	logic [31:0] bReg;
	logic [31:0] aluOut;
	logic [31:0] mdr;
	logic [31:0] rd1;
	logic [31:0] rd2;
	logic [31:0] imm;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] aluResult;

	assign iMemAddr = pc;
	assign cacheAddr = aluOut[addrWidth-1:0];
	assign cacheWdata = bReg;
	assign rfWa = instr.rType.rd;

	always_ff @(posedge CLK) begin
		if (!rstN)
			pc <= '0;
		else if (pcWrite)
			// taken branch uses the target held in aluOut
			pc <= pcSel ? aluOut[addrWidth-1:0] : aluResult[addrWidth-1:0];
	end

	// payload registers
	always_ff @(posedge CLK) begin
		if (irWrite) begin
			instr <= iMemDi;
			oldPc <= pc;
		end
		if (abWrite) begin
			aReg <= rd1;
			bReg <= rd2;
		end
		if (aluOutWrite)
			aluOut <= aluResult;
		if (mdrWrite)
			mdr <= cacheRdata;
	end

	always_comb begin
		case (immSel)
			immS: imm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
			immB: imm = {{19{instr.bType.i12}}, instr.bType.i12, instr.bType.i11,
				instr.bType.i10to5, instr.bType.i4to1, 1'b0};
			immJ: imm = {{11{instr.jType.i20}}, instr.jType.i20, instr.jType.i19to12,
				instr.jType.i11, instr.jType.i10to1, 1'b0};
			default: imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
		endcase
	end

	always_comb begin
		case (aluSrcA)
			2'd0: opA = {{(32-addrWidth){1'b0}}, pc};
			2'd1: opA = {{(32-addrWidth){1'b0}}, oldPc};
			default: opA = aReg;
		endcase
		case (aluSrcB)
			2'd0: opB = bReg;
			2'd1: opB = imm;
			default: opB = 32'd4;
		endcase
	end

	// pc was already advanced in IF, so it is the link value
	always_comb begin
		case (wbSel)
			wbMem: rfWd = mdr;
			wbPc4: rfWd = {{(32-addrWidth){1'b0}}, pc};
			default: rfWd = aluOut;
		endcase
	end

	alu alu0 (
		.a(opA), .b(opB), .op(aluOp), .result(aluResult), .zero(aluZero)
	);

	regFile regFile0 (
		.CLK(CLK), .rstN(rstN), .ra1(instr.rType.rs1), .ra2(instr.rType.rs2),
		.rd1(rd1), .rd2(rd2), .we(rfWe), .wa(rfWa), .wd(rfWd)
	);

endmodule

//--- logic/controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
	input  logic CLK,
	input  logic rstN,
	input  rvPkg::rvInstr instr,
	input  logic aluZero,
	input  logic stall,
	output logic iMemCsN,
	output logic irWrite,
	output logic pcWrite,
	output logic pcSel,
	output logic abWrite,
	output logic aluOutWrite,
	output logic mdrWrite,
	output logic [1:0] aluSrcA,
	output logic [1:0] aluSrcB,
	output logic [1:0] immSel,
	output logic [3:0] aluOp,
	output logic [1:0] wbSel,
	output logic rfWe,
	output logic memRead,
	output logic memWrite,
	output logic halt,
	output logic [31:0] numInst
);
	import rvPkg::*;

	localparam logic [2:0] sIdle   = 3'd0;
	localparam logic [2:0] sIf     = 3'd1;
	localparam logic [2:0] sId     = 3'd2;
	localparam logic [2:0] sEx     = 3'd3;
	localparam logic [2:0] sMem    = 3'd4;
	localparam logic [2:0] sWb     = 3'd5;
	localparam logic [2:0] sHalted = 3'd6;

	logic [2:0] state;
	logic [2:0] nextState;
	logic [6:0] opcode;
	logic [3:0] rOp;
	logic retire;

	assign opcode = instr.rType.opcode;
	assign halt = (state == sHalted);

	// R-type function decode
	always_comb begin
		case (instr.rType.funct3)
			3'b000: rOp = instr.rType.funct7[5] ? aluSub : aluAdd;
			3'b010: rOp = aluSlt;
			3'b100: rOp = aluXor;
			3'b110: rOp = aluOr;
			3'b111: rOp = aluAnd;
			default: rOp = aluAdd;
		endcase
	end

	always_comb begin
		iMemCsN = 1'b1;
		irWrite = 1'b0;
		pcWrite = 1'b0;
		pcSel = 1'b0;
		abWrite = 1'b0;
		aluOutWrite = 1'b0;
		mdrWrite = 1'b0;
		// operand A: 0 pc, 1 old pc, 2 reg A; operand B: 0 reg B, 1 imm, 2 four
		aluSrcA = 2'd2;
		aluSrcB = 2'd0;
		immSel = immI;
		aluOp = aluAdd;
		wbSel = wbAlu;
		rfWe = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		retire = 1'b0;
		nextState = state;
		case (state)
			sIdle: nextState = sIf;
			sIf: begin
				// fetch and pc + 4 in the same cycle
				iMemCsN = 1'b0;
				irWrite = 1'b1;
				aluSrcA = 2'd0;
				aluSrcB = 2'd2;
				pcWrite = 1'b1;
				nextState = sId;
			end
			sId: begin
				// branch target parked in aluOut for EX
				abWrite = 1'b1;
				aluSrcA = 2'd1;
				aluSrcB = 2'd1;
				immSel = immB;
				aluOutWrite = 1'b1;
				nextState = (opcode == opSystem) ? sHalted : sEx;
			end
			sEx: begin
				case (opcode)
					opReg: begin
						aluOp = rOp;
						aluOutWrite = 1'b1;
						nextState = sWb;
					end
					opImm, opLoad, opStore: begin
						aluSrcB = 2'd1;
						immSel = (opcode == opStore) ? immS : immI;
						aluOutWrite = 1'b1;
						nextState = (opcode == opImm) ? sWb : sMem;
					end
					opBranch: begin
						aluOp = aluSub;
						pcSel = 1'b1;
						pcWrite = aluZero;
						retire = 1'b1;
						nextState = sIf;
					end
					opJal: begin
						aluSrcA = 2'd1;
						aluSrcB = 2'd1;
						immSel = immJ;
						pcWrite = 1'b1;
						rfWe = 1'b1;
						wbSel = wbPc4;
						retire = 1'b1;
						nextState = sIf;
					end
					default: begin
						retire = 1'b1;
						nextState = sIf;
					end
				endcase
			end
			sMem: begin
				if (opcode == opLoad) begin
					memRead = 1'b1;
					mdrWrite = !stall;
					nextState = stall ? sMem : sWb;
				end else begin
					memWrite = 1'b1;
					retire = 1'b1;
					nextState = sIf;
				end
			end
			sWb: begin
				rfWe = 1'b1;
				wbSel = (opcode == opLoad) ? wbMem : wbAlu;
				retire = 1'b1;
				nextState = sIf;
			end
			sHalted: nextState = sHalted;
			default: nextState = sIdle;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= sIdle;
			numInst <= '0;
		end else begin
			state <= nextState;
			if (retire)
				numInst <= numInst + 32'd1;
		end
	end

endmodule

//--- logic/dataCache.sv
`timescale 1ns/1ps

module dataCache #(
	parameter int cacheLines = 16
) (
	input  logic CLK,
	input  logic rstN,
	input  logic memRead,
	input  logic memWrite,
	input  logic [rvPkg::addrWidth-1:0] addr,
	input  logic [31:0] wdata,
	output logic [31:0] rdata,
	output logic stall,
	output logic dMemCsN,
	output logic dMemWen,
	output logic [rvPkg::addrWidth-3:0] dMemAddr,
	output logic [31:0] dMemDout,
	input  logic [31:0] dMemDi
);
	import rvPkg::*;

	localparam int idxWidth = $clog2(cacheLines);
	localparam int tagWidth = addrWidth - 2 - idxWidth;

	logic [cacheLines-1:0] valid;
	logic [tagWidth-1:0] tagMem [cacheLines];
	logic [31:0] dataMem [cacheLines];
	logic [idxWidth-1:0] idx;
	logic [tagWidth-1:0] tag;
	logic hit;
	logic missIssue;
	// high in the cycle memory data comes back
	logic fillQ;

	assign idx = addr[idxWidth+1:2];
	assign tag = addr[addrWidth-1:idxWidth+2];
	assign hit = valid[idx] && (tagMem[idx] == tag);
	assign rdata = dataMem[idx];
	assign stall = memRead && !hit;

	// read request goes out once per miss
	assign missIssue = memRead && !hit && !fillQ;

	assign dMemCsN = !(missIssue || memWrite);
	assign dMemWen = memWrite;
	assign dMemAddr = addr[addrWidth-1:2];
	assign dMemDout = wdata;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			valid <= '0;
			fillQ <= 1'b0;
		end else begin
			fillQ <= missIssue;
			if (fillQ)
				valid[idx] <= 1'b1;
		end
	end

	// write-through, only a hit updates the line
	always_ff @(posedge CLK) begin
		if (fillQ) begin
			tagMem[idx] <= tag;
			dataMem[idx] <= dMemDi;
		end else if (memWrite && hit) begin
			dataMem[idx] <= wdata;
		end
	end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic CLK,
	input  logic rstN,
	input  logic [4:0] ra1,
	input  logic [4:0] ra2,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	input  logic we,
	input  logic [4:0] wa,
	input  logic [31:0] wd
);

	logic [31:0] regs [32];

	// x0 reads as zero
	assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [3:0] op,
	output logic [31:0] result,
	output logic zero
);
	import rvPkg::*;

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr:  result = a | b;
			aluXor: result = a ^ b;
			// signed compare
			aluSlt: result = {31'd0, $signed(a) < $signed(b)};
			default: result = '0;
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

//--- logic/rvPkg.sv
package rvPkg;

	// byte address width of pc and both memories
	localparam int addrWidth = 12;

	localparam logic [6:0] opReg    = 7'b0110011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opSystem = 7'b1110011;

	localparam logic [3:0] aluAdd = 4'd0;
	localparam logic [3:0] aluSub = 4'd1;
	localparam logic [3:0] aluAnd = 4'd2;
	localparam logic [3:0] aluOr  = 4'd3;
	localparam logic [3:0] aluXor = 4'd4;
	localparam logic [3:0] aluSlt = 4'd5;

	localparam logic [1:0] immI = 2'd0;
	localparam logic [1:0] immS = 2'd1;
	localparam logic [1:0] immB = 2'd2;
	localparam logic [1:0] immJ = 2'd3;

	localparam logic [1:0] wbAlu = 2'd0;
	localparam logic [1:0] wbMem = 2'd1;
	localparam logic [1:0] wbPc4 = 2'd2;

	// one instruction word, five field layouts
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} rType;
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} iType;
		struct packed {
			logic [6:0] immHi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			logic [6:0] opcode;
		} sType;
		struct packed {
			logic i12;
			logic [5:0] i10to5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] i4to1;
			logic i11;
			logic [6:0] opcode;
		} bType;
		struct packed {
			logic i20;
			logic [9:0] i10to1;
			logic i11;
			logic [7:0] i19to12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} jType;
	} rvInstr;

endpackage
